// File: include/mxu_cfg.svh
// compile-time sizes of the matrix unit, shared by RTL and testbench
// int8 x int8 into int32, with COLUMNS small enough that sums never overflow
`ifndef MXU_CFG_SVH
`define MXU_CFG_SVH

//////////////////////////////
// array geometry
//////////////////////////////
// result elements per vector, one weight row each
`define MXU_ROWS 4
// input elements per vector
`define MXU_COLUMNS 4

//////////////////////////////
// widths and storage
//////////////////////////////
`define MXU_ELEM_W 8
`define MXU_ACC_W 32
// weight pages, each ROWS row words deep
`define MXU_WM_PAGES 4
// vectors per job
`define MXU_COUNT_W 16

`endif

// File: source/mxu_pkg.sv
// shared vector types and control states of the matrix unit
// packed vectors hold element 0 in the low bits
`include "mxu_cfg.svh"

package mxu_pkg;

    //////////////////////////////
    // data path
    //////////////////////////////
    typedef logic signed [`MXU_ELEM_W-1:0] elem_t;
    typedef logic signed [`MXU_ACC_W-1:0] acc_t;
    // one weight row, or one input vector
    typedef logic [`MXU_COLUMNS*`MXU_ELEM_W-1:0] row_word_t;
    // one result vector, row 0 lowest
    typedef logic [`MXU_ROWS*`MXU_ACC_W-1:0] out_vec_t;

    //////////////////////////////
    // addressing and control
    //////////////////////////////
    typedef logic [$clog2(`MXU_WM_PAGES)-1:0] page_t;
    // page * ROWS + row
    typedef logic [$clog2(`MXU_WM_PAGES*`MXU_ROWS)-1:0] wm_addr_t;
    typedef logic [$clog2(`MXU_ROWS)-1:0] row_idx_t;
    typedef logic [`MXU_COUNT_W-1:0] count_t;
    // four registers, 16 bit host data
    typedef logic [1:0] csr_addr_t;
    typedef logic [15:0] csr_data_t;

    // job sequencing of the control unit
    typedef enum logic [2:0] {
        power_up,
        idle,
        fetch_cfg,
        load_weights,
        stream,
        drain,
        finish
    } cu_state_e;

endpackage

// File: source/mxu_ctrl_if.sv
// control unit to systolic array link, no clock of its own
// weight_row and weight_data count only while weight_load is high
`timescale 1ns/10ps

interface mxu_ctrl_if;

    // weight row write into the array
    logic               weight_load;
    mxu_pkg::row_idx_t  weight_row;
    mxu_pkg::row_word_t weight_data;

    // vector accepted this cycle, array captures in_data
    logic inject;

    // output held and not taken
    logic stall;
    // any valid item in the pipeline
    logic busy;

    modport ctrl (
        output weight_load,
        output weight_row,
        output weight_data,
        output inject,
        input  stall,
        input  busy
    );

    modport array (
        input  weight_load,
        input  weight_row,
        input  weight_data,
        input  inject,
        output stall,
        output busy
    );

endinterface

// File: source/csr_file.sv
// host registers: page (0), count (1), job counter (2, ro), error flag (3, ro)
// reads return one cycle after csr_re; reading the flag clears it
`timescale 1ns/10ps

module csr_file (
    input  logic               clk,
    input  logic               reset,
    input  logic               csr_we,
    input  logic               csr_re,
    input  mxu_pkg::csr_addr_t csr_addr,
    input  mxu_pkg::csr_data_t csr_wdata,
    input  logic               job_done,
    output mxu_pkg::csr_data_t csr_rdata,
    output mxu_pkg::page_t     page,
    output mxu_pkg::count_t    count
);

    localparam mxu_pkg::csr_addr_t addr_page  = 2'd0;
    localparam mxu_pkg::csr_addr_t addr_count = 2'd1;
    localparam mxu_pkg::csr_addr_t addr_jobs  = 2'd2;

    mxu_pkg::csr_data_t job_cnt_q;
    logic               err_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            page      <= '0;
            count     <= '0;
            job_cnt_q <= '0;
            err_q     <= 1'b0;
            csr_rdata <= '0;
        end else begin
            // host writes, ro addresses only flag an error
            if (csr_we) begin
                case (csr_addr)
                    addr_page:  page  <= mxu_pkg::page_t'(csr_wdata);
                    addr_count: count <= mxu_pkg::count_t'(csr_wdata);
                    default:    err_q <= 1'b1;
                endcase
            end
            // one count per cs_done pulse
            if (job_done) begin
                job_cnt_q <= job_cnt_q + 1'b1;
            end
            // registered read
            if (csr_re) begin
                case (csr_addr)
                    addr_page:  csr_rdata <= mxu_pkg::csr_data_t'(page);
                    addr_count: csr_rdata <= mxu_pkg::csr_data_t'(count);
                    addr_jobs:  csr_rdata <= job_cnt_q;
                    default: begin
                        csr_rdata <= mxu_pkg::csr_data_t'(err_q);
                        err_q     <= 1'b0;
                    end
                endcase
            end
        end
    end

    // host port is one access per cycle
    assert property (@(posedge clk) disable iff (reset) !(csr_we && csr_re));

endmodule

// File: source/weight_memory.sv
// weight pages, one row word per address, no reset of the contents
// read data is valid the cycle after rd_en
`timescale 1ns/10ps
`include "mxu_cfg.svh"

module weight_memory (
    input  logic               clk,
    input  logic               wm_we,
    input  mxu_pkg::wm_addr_t  wm_waddr,
    input  mxu_pkg::row_word_t wm_wdata,
    input  logic               rd_en,
    input  mxu_pkg::wm_addr_t  rd_addr,
    output mxu_pkg::row_word_t rd_data
);

    localparam int wm_depth = `MXU_WM_PAGES * `MXU_ROWS;

    // page p row r at p * ROWS + r
    mxu_pkg::row_word_t mem [wm_depth];

    always_ff @(posedge clk) begin
        // host side
        if (wm_we) begin
            mem[wm_waddr] <= wm_wdata;
        end
        // control unit side, registered
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: source/control_unit.sv
// job FSM: config fetch, weight load, gated input stream, drain
// host keeps page, count and weights still while a job runs
`timescale 1ns/10ps
`include "mxu_cfg.svh"

module control_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               cs_start,
    input  mxu_pkg::page_t     page,
    input  mxu_pkg::count_t    count,
    input  logic               in_valid,
    input  mxu_pkg::row_word_t wm_rd_data,
    output logic               cs_idle,
    output logic               cs_ready,
    output logic               cs_done,
    output logic               in_ready,
    output logic               wm_rd_en,
    output mxu_pkg::wm_addr_t  wm_rd_addr,
    mxu_ctrl_if.ctrl           ctrl
);

    localparam int step_w = $clog2(`MXU_ROWS + 1);
    localparam logic [step_w-1:0] last_step = step_w'(`MXU_ROWS);

    mxu_pkg::cu_state_e state_q;
    // sub-cycle of fetch_cfg, row counter of load_weights
    logic [step_w-1:0]  step_q;
    mxu_pkg::page_t     page_q;
    mxu_pkg::count_t    remain_q;
    // weight read in flight, and the row it belongs to
    logic               rd_valid_q;
    mxu_pkg::row_idx_t  rd_row_q;
    mxu_pkg::row_idx_t  load_row;
    logic               accept;

    //////////////////////////////
    // weight row reads
    //////////////////////////////
    assign load_row   = mxu_pkg::row_idx_t'(step_q);
    assign wm_rd_en   = (state_q == mxu_pkg::load_weights) && (step_q < last_step);
    assign wm_rd_addr = mxu_pkg::wm_addr_t'(page_q * `MXU_ROWS + load_row);

    // returned row goes straight into the array
    assign ctrl.weight_load = rd_valid_q;
    assign ctrl.weight_row  = rd_row_q;
    assign ctrl.weight_data = wm_rd_data;

    //////////////////////////////
    // handshakes
    //////////////////////////////
    assign cs_idle  = state_q == mxu_pkg::idle;
    // config latched, first load cycle
    assign cs_ready = (state_q == mxu_pkg::load_weights) && (step_q == '0);
    assign cs_done  = state_q == mxu_pkg::finish;

    // no accept while the array is frozen
    assign in_ready    = (state_q == mxu_pkg::stream) && (remain_q != '0) && !ctrl.stall;
    assign accept      = in_valid && in_ready;
    assign ctrl.inject = accept;

    //////////////////////////////
    // state machine
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= mxu_pkg::power_up;
            step_q     <= '0;
            page_q     <= '0;
            remain_q   <= '0;
            rd_valid_q <= 1'b0;
            rd_row_q   <= '0;
        end else begin
            // memory latency of one cycle
            rd_valid_q <= wm_rd_en;
            rd_row_q   <= load_row;
            case (state_q)
                mxu_pkg::power_up: begin
                    state_q <= mxu_pkg::idle;
                end
                mxu_pkg::idle: begin
                    if (cs_start) begin
                        step_q  <= '0;
                        state_q <= mxu_pkg::fetch_cfg;
                    end
                end
                mxu_pkg::fetch_cfg: begin
                    // page first, then count
                    if (step_q == '0) begin
                        page_q <= page;
                        step_q <= step_q + 1'b1;
                    end else begin
                        remain_q <= count;
                        step_q   <= '0;
                        state_q  <= mxu_pkg::load_weights;
                    end
                end
                mxu_pkg::load_weights: begin
                    // ROWS reads plus one for the last return
                    if (step_q == last_step) begin
                        step_q  <= '0;
                        state_q <= (remain_q == '0) ? mxu_pkg::drain : mxu_pkg::stream;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                mxu_pkg::stream: begin
                    if (accept) begin
                        remain_q <= remain_q - 1'b1;
                        if (remain_q == mxu_pkg::count_t'(1)) begin
                            state_q <= mxu_pkg::drain;
                        end
                    end
                end
                mxu_pkg::drain: begin
                    // last result taken by the host
                    if (!ctrl.busy) begin
                        state_q <= mxu_pkg::finish;
                    end
                end
                mxu_pkg::finish: begin
                    state_q <= mxu_pkg::idle;
                end
                default: begin
                    state_q <= mxu_pkg::idle;
                end
            endcase
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////
    assert property (@(posedge clk) disable iff (reset) !(cs_ready && cs_done));
    assert property (@(posedge clk) disable iff (reset)
        (state_q != mxu_pkg::stream) |-> !in_ready);
    // stream always has a vector left, so the count never wraps
    assert property (@(posedge clk) disable iff (reset)
        (state_q == mxu_pkg::stream) |-> (remain_q != '0));

endmodule

// File: source/systolic_array.sv
// weight-stationary array, COLUMNS+ROWS cycles from accept to out_valid
// a held output freezes every stage; weight rows load even while frozen
`timescale 1ns/10ps
`include "mxu_cfg.svh"

module systolic_array (
    input  logic               clk,
    input  logic               reset,
    input  mxu_pkg::row_word_t in_data,
    input  logic               out_ready,
    output logic               out_valid,
    output mxu_pkg::out_vec_t  out_data,
    mxu_ctrl_if.array          ctrl
);

    localparam int rows    = `MXU_ROWS;
    localparam int cols    = `MXU_COLUMNS;
    localparam int latency = rows + cols;

    mxu_pkg::elem_t weight_q [rows][cols];
    // inputs passed down to the next row
    mxu_pkg::elem_t x_q [rows-1][cols];
    // partial sums moving along the row
    mxu_pkg::acc_t  psum_q [rows][cols];
    mxu_pkg::elem_t skew_out [cols];
    logic [latency:0] valid_q;
    logic             stall;

    //////////////////////////////
    // valid pipeline and stall
    //////////////////////////////
    assign stall      = out_valid && !out_ready;
    assign out_valid  = valid_q[latency];
    assign ctrl.stall = stall;
    assign ctrl.busy  = |valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (!stall) begin
            valid_q <= {valid_q[latency-1:0], ctrl.inject};
        end
    end

    genvar r, c;

    //////////////////////////////
    // input skew
    //////////////////////////////
    // element c waits c cycles behind the capture stage
    for (c = 0; c < cols; c++) begin : g_skew
        mxu_pkg::elem_t sk_q [c+1];

        always_ff @(posedge clk) begin
            if (!stall) begin
                // zeros on empty slots
                sk_q[0] <= ctrl.inject ? in_data[c*`MXU_ELEM_W +: `MXU_ELEM_W] : '0;
                for (int k = 1; k <= c; k++) begin
                    sk_q[k] <= sk_q[k-1];
                end
            end
        end

        assign skew_out[c] = sk_q[c];
    end

    //////////////////////////////
    // processing elements
    //////////////////////////////
    for (r = 0; r < rows; r++) begin : g_row
        for (c = 0; c < cols; c++) begin : g_col
            mxu_pkg::elem_t x_in;
            mxu_pkg::acc_t  ps_in;

            // top row from the skew, others from above
            if (r == 0) begin : g_x_top
                assign x_in = skew_out[c];
            end else begin : g_x_mid
                assign x_in = x_q[r-1][c];
            end
            // first column starts each sum at zero
            if (c == 0) begin : g_ps_first
                assign ps_in = '0;
            end else begin : g_ps_next
                assign ps_in = psum_q[r][c-1];
            end

            always_ff @(posedge clk) begin
                if (ctrl.weight_load && ctrl.weight_row == mxu_pkg::row_idx_t'(r)) begin
                    weight_q[r][c] <= ctrl.weight_data[c*`MXU_ELEM_W +: `MXU_ELEM_W];
                end
                if (!stall) begin
                    // signed mac at accumulator width
                    psum_q[r][c] <= ps_in + weight_q[r][c] * x_in;
                end
            end

            // bottom row keeps no copy of x
            if (r < rows - 1) begin : g_pass
                always_ff @(posedge clk) begin
                    if (!stall) begin
                        x_q[r][c] <= x_in;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // output deskew
    //////////////////////////////
    // row r finishes r cycles after row 0, so it waits ROWS-r stages
    for (r = 0; r < rows; r++) begin : g_deskew
        mxu_pkg::acc_t dq [rows-r];

        always_ff @(posedge clk) begin
            if (!stall) begin
                dq[0] <= psum_q[r][cols-1];
                for (int k = 1; k < rows - r; k++) begin
                    dq[k] <= dq[k-1];
                end
            end
        end

        assign out_data[r*`MXU_ACC_W +: `MXU_ACC_W] = dq[rows-r-1];
    end

    // held result stays put until taken
    assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)));

endmodule

// File: source/mxu_top.sv
// matrix-vector engine: registers, weight pages, control unit, systolic array
// no host writes to registers or weights while cs_idle is low
`timescale 1ns/10ps

module mxu_top (
    input  logic               clk,
    input  logic               reset,
    // job handshake
    input  logic               cs_start,
    output logic               cs_idle,
    output logic               cs_ready,
    output logic               cs_done,
    // register port
    input  logic               csr_we,
    input  logic               csr_re,
    input  mxu_pkg::csr_addr_t csr_addr,
    input  mxu_pkg::csr_data_t csr_wdata,
    output mxu_pkg::csr_data_t csr_rdata,
    // weight write port
    input  logic               wm_we,
    input  mxu_pkg::wm_addr_t  wm_waddr,
    input  mxu_pkg::row_word_t wm_wdata,
    // input vectors
    input  logic               in_valid,
    input  mxu_pkg::row_word_t in_data,
    output logic               in_ready,
    // result vectors
    output logic               out_valid,
    output mxu_pkg::out_vec_t  out_data,
    input  logic               out_ready
);

    mxu_pkg::page_t     page;
    mxu_pkg::count_t    count;
    logic               wm_rd_en;
    mxu_pkg::wm_addr_t  wm_rd_addr;
    mxu_pkg::row_word_t wm_rd_data;

    mxu_ctrl_if ctrl_if ();

    // job counter follows cs_done
    csr_file csr_file_i (
        .clk       (clk),
        .reset     (reset),
        .csr_we    (csr_we),
        .csr_re    (csr_re),
        .csr_addr  (csr_addr),
        .csr_wdata (csr_wdata),
        .job_done  (cs_done),
        .csr_rdata (csr_rdata),
        .page      (page),
        .count     (count)
    );

    weight_memory weight_memory_i (
        .clk      (clk),
        .wm_we    (wm_we),
        .wm_waddr (wm_waddr),
        .wm_wdata (wm_wdata),
        .rd_en    (wm_rd_en),
        .rd_addr  (wm_rd_addr),
        .rd_data  (wm_rd_data)
    );

    control_unit control_unit_i (
        .clk        (clk),
        .reset      (reset),
        .cs_start   (cs_start),
        .page       (page),
        .count      (count),
        .in_valid   (in_valid),
        .wm_rd_data (wm_rd_data),
        .cs_idle    (cs_idle),
        .cs_ready   (cs_ready),
        .cs_done    (cs_done),
        .in_ready   (in_ready),
        .wm_rd_en   (wm_rd_en),
        .wm_rd_addr (wm_rd_addr),
        .ctrl       (ctrl_if.ctrl)
    );

    systolic_array systolic_array_i (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .ctrl      (ctrl_if.array)
    );

endmodule

// File: tb/tb_mxu_top.sv
// random jobs on all weight pages, checked against a model of W*x
// host register and weight writes happen only while the DUT is idle
`timescale 1ns/10ps
`include "mxu_cfg.svh"

module tb_mxu_top;

    localparam int clk_period = 4;
    localparam int n_jobs     = 6;
    localparam int wm_depth   = `MXU_WM_PAGES * `MXU_ROWS;

    logic               clk;
    logic               reset;
    logic               cs_start;
    logic               cs_idle;
    logic               cs_ready;
    logic               cs_done;
    logic               csr_we;
    logic               csr_re;
    mxu_pkg::csr_addr_t csr_addr;
    mxu_pkg::csr_data_t csr_wdata;
    mxu_pkg::csr_data_t csr_rdata;
    logic               wm_we;
    mxu_pkg::wm_addr_t  wm_waddr;
    mxu_pkg::row_word_t wm_wdata;
    logic               in_valid;
    mxu_pkg::row_word_t in_data;
    logic               in_ready;
    logic               out_valid;
    mxu_pkg::out_vec_t  out_data;
    logic               out_ready;

    // job list, each job on another page than the one before, one empty job
    mxu_pkg::page_t  job_page [n_jobs]  = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd1, 2'd2};
    mxu_pkg::count_t job_count [n_jobs] = '{16'd20, 16'd35, 16'd0, 16'd50, 16'd12, 16'd40};

    integer seed = 32'h517cd824;

    // mirrors of weights and registers
    mxu_pkg::row_word_t wmir [wm_depth];
    mxu_pkg::page_t     page_m;
    mxu_pkg::count_t    count_m;
    // vectors still to offer, results still to come
    mxu_pkg::row_word_t in_q [$];
    mxu_pkg::out_vec_t  exp_q [$];

    // job progress
    logic              job_active;
    logic              start_req;
    logic              in_taken;
    logic              held;
    mxu_pkg::out_vec_t held_data;
    int                job_n;
    int                accepted;
    int                ready_cnt;
    int                done_cnt;
    int                jobs_done;

    mxu_top mxu_top_i (.*);

    always #(clk_period / 2) clk = ~clk;

    //////////////////////////////
    // compare and stop
    //////////////////////////////
    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_out_vec(input string name, input mxu_pkg::out_vec_t expected,
                                 input mxu_pkg::out_vec_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Error at %0d ns: %s expected %h, got %h",
                $time, name, expected, actual));
        end
    endtask

    task automatic check_csr(input string name, input mxu_pkg::csr_data_t expected,
                             input mxu_pkg::csr_data_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Error at %0d ns: %s expected %h, got %h",
                $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("Error at %0d ns: %s expected %b, got %b",
                $time, name, expected, actual));
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////
    // element r = sum over c of W[page][r][c] * x[c], all signed
    function automatic mxu_pkg::out_vec_t expected_result(input mxu_pkg::page_t pg,
                                                          input mxu_pkg::row_word_t x);
        mxu_pkg::out_vec_t  res;
        mxu_pkg::acc_t      acc;
        mxu_pkg::elem_t     w;
        mxu_pkg::elem_t     xe;
        mxu_pkg::row_word_t wrow;
        res = '0;
        for (int r = 0; r < `MXU_ROWS; r++) begin
            wrow = wmir[int'(pg) * `MXU_ROWS + r];
            acc  = '0;
            for (int c = 0; c < `MXU_COLUMNS; c++) begin
                w   = wrow[c*`MXU_ELEM_W +: `MXU_ELEM_W];
                xe  = x[c*`MXU_ELEM_W +: `MXU_ELEM_W];
                acc = acc + mxu_pkg::acc_t'(w) * mxu_pkg::acc_t'(xe);
            end
            res[r*`MXU_ACC_W +: `MXU_ACC_W] = acc;
        end
        return res;
    endfunction

    // reset, weights and register tests, then a slow stream per job
    function automatic int budget_cycles();
        int total;
        total = 400;
        for (int j = 0; j < n_jobs; j++) begin
            total += 80 + 16 * int'(job_count[j]);
        end
        return total;
    endfunction

    //////////////////////////////
    // host port access
    //////////////////////////////
    task automatic write_csr(input mxu_pkg::csr_addr_t addr, input mxu_pkg::csr_data_t data);
        @(negedge clk);
        csr_we    = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(negedge clk);
        csr_we = 1'b0;
        // only page and count are writable
        if (addr == 2'd0) begin
            page_m = mxu_pkg::page_t'(data);
        end else if (addr == 2'd1) begin
            count_m = mxu_pkg::count_t'(data);
        end
    endtask

    // data registered one cycle after csr_re
    task automatic read_csr(input mxu_pkg::csr_addr_t addr, output mxu_pkg::csr_data_t data);
        @(negedge clk);
        csr_re   = 1'b1;
        csr_addr = addr;
        @(negedge clk);
        csr_re = 1'b0;
        #1;
        data = csr_rdata;
    endtask

    task automatic write_weight(input mxu_pkg::wm_addr_t addr, input mxu_pkg::row_word_t data);
        @(negedge clk);
        wm_we    = 1'b1;
        wm_waddr = addr;
        wm_wdata = data;
        @(negedge clk);
        wm_we       = 1'b0;
        wmir[addr] = data;
    endtask

    //////////////////////////////
    // one clock of stream traffic
    //////////////////////////////
    task automatic tick();
        @(negedge clk);
        cs_start = start_req;
        if (in_taken) begin
            in_valid = 1'b0;
            in_taken = 1'b0;
        end
        // offered vector stays until taken, random gaps otherwise
        if (!in_valid) begin
            if (in_q.size() > 0 && ($random(seed) & 3) != 0) begin
                in_valid = 1'b1;
                in_data  = in_q.pop_front();
            end else begin
                in_data = $random(seed);
            end
        end
        out_ready = ($random(seed) & 3) != 0;
        // sample midway to the rising edge
        #1;
        if (held) begin
            check_flag("out_valid", 1'b1, out_valid);
            check_out_vec("out_data", held_data, out_data);
        end
        // frozen array takes no input
        if (out_valid && !out_ready) begin
            check_flag("in_ready", 1'b0, in_ready);
        end
        if (!job_active || accepted == job_n) begin
            check_flag("in_ready", 1'b0, in_ready);
        end
        if (!job_active) begin
            check_flag("cs_idle", 1'b1, cs_idle);
        end
        if (cs_ready) begin
            ready_cnt++;
            start_req = 1'b0;
            if (accepted != 0) begin
                stop_on_error("cs_ready came after the first input vector was accepted");
            end
        end
        if (in_valid && in_ready) begin
            if (ready_cnt == 0) begin
                stop_on_error("an input vector was accepted before cs_ready");
            end
            accepted++;
            exp_q.push_back(expected_result(page_m, in_data));
            in_taken = 1'b1;
        end
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                stop_on_error("a result came out with no input vector pending");
            end
            check_out_vec("out_data", exp_q.pop_front(), out_data);
        end
        held      = out_valid && !out_ready;
        held_data = out_data;
        // job end only after the last result was taken
        if (cs_done) begin
            done_cnt++;
            check_flag("out_valid", 1'b0, out_valid);
            if (exp_q.size() != 0 || accepted != job_n) begin
                stop_on_error("cs_done came before all vectors and results were through");
            end
        end
    endtask

    //////////////////////////////
    // test sequences
    //////////////////////////////
    task automatic check_registers();
        mxu_pkg::csr_data_t rd;
        write_csr(2'd0, mxu_pkg::csr_data_t'($random(seed) & 3));
        write_csr(2'd1, mxu_pkg::csr_data_t'($random(seed)));
        // read-only addresses, each sets the flag once
        for (int a = 2; a < 4; a++) begin
            write_csr(mxu_pkg::csr_addr_t'(a), mxu_pkg::csr_data_t'($random(seed)));
            read_csr(2'd0, rd);
            check_csr("page", mxu_pkg::csr_data_t'(page_m), rd);
            read_csr(2'd1, rd);
            check_csr("count", count_m, rd);
            read_csr(2'd2, rd);
            check_csr("job counter", mxu_pkg::csr_data_t'(jobs_done), rd);
            read_csr(2'd3, rd);
            check_flag("error flag", 1'b1, rd[0]);
            read_csr(2'd3, rd);
            check_flag("error flag", 1'b0, rd[0]);
        end
    endtask

    task automatic run_job(input mxu_pkg::page_t pg, input mxu_pkg::count_t n);
        mxu_pkg::csr_data_t rd;
        write_csr(2'd0, mxu_pkg::csr_data_t'(pg));
        write_csr(2'd1, mxu_pkg::csr_data_t'(n));
        read_csr(2'd0, rd);
        check_csr("page", mxu_pkg::csr_data_t'(page_m), rd);
        read_csr(2'd1, rd);
        check_csr("count", count_m, rd);
        for (int i = 0; i < int'(n); i++) begin
            in_q.push_back($random(seed));
        end
        job_n      = int'(n);
        accepted   = 0;
        ready_cnt  = 0;
        done_cnt   = 0;
        job_active = 1'b1;
        start_req  = 1'b1;
        while (done_cnt == 0) begin
            tick();
        end
        job_active = 1'b0;
        // idle again, no late pulses
        repeat (3) tick();
        if (ready_cnt != 1 || done_cnt != 1) begin
            stop_on_error("cs_ready or cs_done did not pulse exactly once in a job");
        end
        jobs_done++;
        read_csr(2'd2, rd);
        check_csr("job counter", mxu_pkg::csr_data_t'(jobs_done), rd);
    endtask

    initial begin : watchdog
        #(budget_cycles() * clk_period);
        stop_on_error("watchdog expired: the DUT stopped making progress and the run hung");
    end

    initial begin : stimulus
        clk        = 1'b0;
        reset      = 1'b1;
        cs_start   = 1'b0;
        csr_we     = 1'b0;
        csr_re     = 1'b0;
        csr_addr   = '0;
        csr_wdata  = '0;
        wm_we      = 1'b0;
        wm_waddr   = '0;
        wm_wdata   = '0;
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b0;
        page_m     = '0;
        count_m    = '0;
        job_active = 1'b0;
        start_req  = 1'b0;
        in_taken   = 1'b0;
        held       = 1'b0;
        held_data  = '0;
        job_n      = 0;
        accepted   = 0;
        ready_cnt  = 0;
        done_cnt   = 0;
        jobs_done  = 0;
        repeat (16) @(negedge clk);
        reset = 1'b0;
        // power_up cycle, all handshakes quiet
        #1;
        check_flag("cs_idle", 1'b0, cs_idle);
        check_flag("cs_ready", 1'b0, cs_ready);
        check_flag("cs_done", 1'b0, cs_done);
        check_flag("in_ready", 1'b0, in_ready);
        check_flag("out_valid", 1'b0, out_valid);
        tick();
        for (int a = 0; a < wm_depth; a++) begin
            write_weight(mxu_pkg::wm_addr_t'(a), $random(seed));
        end
        check_registers();
        for (int j = 0; j < n_jobs; j++) begin
            run_job(job_page[j], job_count[j]);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// File: mxu_accel.f
+incdir+include
source/mxu_pkg.sv
source/mxu_ctrl_if.sv
source/csr_file.sv
source/weight_memory.sv
source/control_unit.sv
source/systolic_array.sv
source/mxu_top.sv
tb/tb_mxu_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f mxu_accel.f --top-module tb_mxu_top \
    -o sim_mxu &&
./obj_dir/sim_mxu | tee /dev/stderr | grep -F -e '** PASS **' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
